// ==== Makefile ====
SIM      := verilator
SIMFLAGS := --binary --timing --assert -j 0
TOP      := tb_board_shell
FILELIST := tb.f

OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := Finished with no errors
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard *.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== board_shell.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_shell (
  input  wire logic                  soc_clk,
  input  wire logic                  rst_n,
  // register bus from the soc
  input  wire logic                  reg_req_valid_i,
  output logic                       reg_req_ready_o,
  input  wire logic                  reg_req_write_i,
  input  wire shell_pkg::addr_t      reg_req_addr_i,
  input  wire shell_pkg::data_t      reg_req_wdata_i,
  output logic                       reg_rsp_valid_o,
  input  wire logic                  reg_rsp_ready_i,
  output shell_pkg::data_t           reg_rsp_rdata_o,
  output logic                       reg_rsp_error_o,
  // spi host of the soc
  input  wire logic                  spih_sck_i,
  input  wire logic                  spih_sck_en_i,
  input  wire logic [1:0]            spih_csb_i,
  input  wire logic [1:0]            spih_csb_en_i,
  input  wire logic [3:0]            spih_sd_i,
  input  wire logic [3:0]            spih_sd_en_i,
  output logic [3:0]                 spih_sd_o,
  // fan and rtc
  input  wire shell_pkg::fan_level_t fan_sw_i,
  output logic                       fan_pwm_o,
  output logic                       rtc_clk_o,
  // sd card
  output logic                       sd_cmd_o,
  output logic                       sd_sclk_o,
  output logic                       sd_cs_o,
  output logic                       sd_reset_o,
  input  wire logic                  sd_dat0_i,
  // qspi flash
  output logic                       qspi_clk_o,
  output logic                       qspi_cs_b_o,
  input  wire logic                  qspi_dq0_i
);
  import shell_pkg::*;

  reg_bus_if  i_reg_bus ();
  spi_host_if i_spi_host ();

  data_t    rtc_ticks;
  fan_cfg_t fan_cfg;

  ////////////////////////////////
  // plain ports onto the bundles
  ////////////////////////////////

  // register request and response
  assign i_reg_bus.req_valid = reg_req_valid_i;
  assign i_reg_bus.req_write = reg_req_write_i;
  assign i_reg_bus.req_addr  = reg_req_addr_i;
  assign i_reg_bus.req_wdata = reg_req_wdata_i;
  assign i_reg_bus.rsp_ready = reg_rsp_ready_i;
  assign reg_req_ready_o     = i_reg_bus.req_ready;
  assign reg_rsp_valid_o     = i_reg_bus.rsp_valid;
  assign reg_rsp_rdata_o     = i_reg_bus.rsp_rdata;
  assign reg_rsp_error_o     = i_reg_bus.rsp_error;

  // spi host, data from the host on sd_o
  assign i_spi_host.sck    = spih_sck_i;
  assign i_spi_host.sck_en = spih_sck_en_i;
  assign i_spi_host.csb    = spih_csb_i;
  assign i_spi_host.csb_en = spih_csb_en_i;
  assign i_spi_host.sd_o   = spih_sd_i;
  assign i_spi_host.sd_en  = spih_sd_en_i;
  assign spih_sd_o         = i_spi_host.sd_i;

  ////////////////////////////////
  // blocks
  ////////////////////////////////

  reg_frontend i_reg_frontend (
    .soc_clk     ( soc_clk   ),
    .rst_n       ( rst_n     ),
    .bus         ( i_reg_bus ),
    .rtc_ticks_i ( rtc_ticks ),
    .fan_cfg_o   ( fan_cfg   )
  );

  rtc_divider i_rtc_divider (
    .soc_clk     ( soc_clk   ),
    .rst_n       ( rst_n     ),
    .rtc_clk_o   ( rtc_clk_o ),
    .rtc_ticks_o ( rtc_ticks )
  );

  fan_ctrl i_fan_ctrl (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( rst_n     ),
    .fan_sw_i  ( fan_sw_i  ),
    .fan_cfg_i ( fan_cfg   ),
    .fan_pwm_o ( fan_pwm_o )
  );

  spi_pad_adapter i_spi_pad_adapter (
    .spi         ( i_spi_host  ),
    .sd_cmd_o    ( sd_cmd_o    ),
    .sd_sclk_o   ( sd_sclk_o   ),
    .sd_cs_o     ( sd_cs_o     ),
    .sd_reset_o  ( sd_reset_o  ),
    .sd_dat0_i   ( sd_dat0_i   ),
    .qspi_clk_o  ( qspi_clk_o  ),
    .qspi_cs_b_o ( qspi_cs_b_o ),
    .qspi_dq0_i  ( qspi_dq0_i  )
  );

endmodule

`default_nettype wire

// ==== fan_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "shell_defs.svh"

module fan_ctrl (
  input  wire logic                  soc_clk,
  input  wire logic                  rst_n,
  input  wire shell_pkg::fan_level_t fan_sw_i,
  input  wire shell_pkg::fan_cfg_t   fan_cfg_i,
  output logic                       fan_pwm_o
);
  import shell_pkg::*;

  localparam int unsigned CYC_W  = $clog2(`FAN_STEP_CYCLES);
  localparam int unsigned STEP_W = $clog2(`FAN_STEPS);

  logic [CYC_W-1:0]  cyc_q;
  logic [STEP_W-1:0] step_q;
  logic              step_end;
  logic              period_end;
  fan_level_t        level_sel;
  fan_level_t        level_q;

  // software override wins over the board switches
  assign level_sel = fan_cfg_i.ovr_en ? fan_cfg_i.level : fan_sw_i;

  // last cycle of a step
  assign step_end   = (cyc_q == CYC_W'(`FAN_STEP_CYCLES - 1));
  // last cycle of the whole pwm period
  assign period_end = step_end && (step_q == STEP_W'(`FAN_STEPS - 1));

  ////////////////////////////////
  // step and cycle counters
  ////////////////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc_q   <= '0;
      step_q  <= '0;
      level_q <= '0;
    end else begin
      if (step_end) begin
        cyc_q <= '0;
      end else begin
        cyc_q <= cyc_q + 1'b1;
      end
      if (period_end) begin
        step_q  <= '0;
        // new level only at a period start
        level_q <= level_sel;
      end else if (step_end) begin
        step_q <= step_q + 1'b1;
      end
    end
  end

  // high during the first level_q steps
  // level 0 never matches, so the fan stays off
  assign fan_pwm_o = (step_q < level_q);

  // a zero level holds for the whole period and keeps the output low
  a_zero_level_low: assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    (level_q == '0 && !period_end) |=> (level_q == '0 && !fan_pwm_o)
  );

endmodule

`default_nettype wire

// ==== reg_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// valid/ready register bus
// one request channel, one response channel
interface reg_bus_if;
  import shell_pkg::*;

  // request channel
  logic  req_valid;
  logic  req_ready;
  logic  req_write;
  addr_t req_addr;
  data_t req_wdata;

  // response channel
  logic  rsp_valid;
  logic  rsp_ready;
  data_t rsp_rdata;
  logic  rsp_error;

  // register side
  modport target (
    input  req_valid, req_write, req_addr, req_wdata, rsp_ready,
    output req_ready, rsp_valid, rsp_rdata, rsp_error
  );

  // soc side
  modport initiator (
    output req_valid, req_write, req_addr, req_wdata, rsp_ready,
    input  req_ready, rsp_valid, rsp_rdata, rsp_error
  );

endinterface

`default_nettype wire

// ==== reg_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "shell_defs.svh"

module reg_frontend (
  input  wire logic             soc_clk,
  input  wire logic             rst_n,
  reg_bus_if.target             bus,
  input  wire shell_pkg::data_t rtc_ticks_i,
  output shell_pkg::fan_cfg_t   fan_cfg_o
);
  import shell_pkg::*;

  rsp_state_e state_q;
  rsp_state_e state_d;
  shell_reg_e reg_sel;
  logic       reg_hit;
  logic       req_fire;
  logic       rsp_fire;
  logic       fan_write;
  data_t      rdata_d;
  logic       error_d;
  data_t      rdata_q;
  logic       error_q;
  fan_cfg_t   fan_cfg_q;

  // handshakes
  assign req_fire = bus.req_valid && bus.req_ready;
  assign rsp_fire = bus.rsp_valid && bus.rsp_ready;

  ////////////////////////////////
  // address decode
  ////////////////////////////////

  always_comb begin
    reg_hit = 1'b1;
    reg_sel = REG_FAN;
    case (bus.req_addr)
      `REG_FAN_OFFS: reg_sel = REG_FAN;
      `REG_RTC_OFFS: reg_sel = REG_RTC;
      default:       reg_hit = 1'b0;
    endcase
  end

  // response word for the current request
  always_comb begin
    rdata_d = '0;
    error_d = 1'b0;
    if (!reg_hit || (bus.req_write && reg_sel == REG_RTC)) begin
      // unmapped address or write to the read only rtc
      rdata_d = `REG_ERR_VAL;
      error_d = 1'b1;
    end else if (!bus.req_write) begin
      case (reg_sel)
        REG_FAN: rdata_d[$bits(fan_cfg_t)-1:0] = fan_cfg_q;
        REG_RTC: rdata_d = rtc_ticks_i;
        default: rdata_d = `REG_ERR_VAL;
      endcase
    end
  end

  // only a legal fan write changes state
  assign fan_write = req_fire && bus.req_write && reg_hit && (reg_sel == REG_FAN);

  ////////////////////////////////
  // response slot
  ////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      RSP_IDLE:    if (req_fire) state_d = RSP_PENDING;
      RSP_PENDING: if (rsp_fire) state_d = RSP_IDLE;
      default:     state_d = RSP_IDLE;
    endcase
  end

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= RSP_IDLE;
      fan_cfg_q <= '0;
    end else begin
      state_q <= state_d;
      if (fan_write) begin
        // bit 4 override, bits 3:0 level
        fan_cfg_q <= bus.req_wdata[$bits(fan_cfg_t)-1:0];
      end
    end
  end

  // payload captured at acceptance, held until the response completes
  always_ff @(posedge soc_clk) begin
    if (req_fire) begin
      rdata_q <= rdata_d;
      error_q <= error_d;
    end
  end

  // one item in flight
  assign bus.req_ready = (state_q == RSP_IDLE);
  assign bus.rsp_valid = (state_q == RSP_PENDING);
  assign bus.rsp_rdata = rdata_q;
  assign bus.rsp_error = error_q;

  assign fan_cfg_o = fan_cfg_q;

  // a stalled response keeps its payload
  a_rsp_stable: assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    (bus.rsp_valid && !bus.rsp_ready) |=>
      (bus.rsp_valid && $stable(bus.rsp_rdata) && $stable(bus.rsp_error))
  );

endmodule

`default_nettype wire

// ==== rtc_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "shell_defs.svh"

module rtc_divider (
  input  wire logic        soc_clk,
  input  wire logic        rst_n,
  output logic             rtc_clk_o,
  output shell_pkg::data_t rtc_ticks_o
);

  // enough bits for 0 .. RTC_HALF_CYCLES-1
  localparam int unsigned CNT_W = $clog2(`RTC_HALF_CYCLES);

  logic [CNT_W-1:0] half_cnt_q;
  logic             half_wrap;

  // last cycle of a half period
  assign half_wrap = (half_cnt_q == CNT_W'(`RTC_HALF_CYCLES - 1));

  ////////////////////////////////
  // divider and tick counter
  ////////////////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      half_cnt_q  <= '0;
      rtc_clk_o   <= 1'b0;
      rtc_ticks_o <= '0;
    end else begin
      if (half_wrap) begin
        half_cnt_q <= '0;
        // toggle flop, rtc clock starts low
        rtc_clk_o  <= ~rtc_clk_o;
        // count on the low to high transition only
        if (!rtc_clk_o) begin
          rtc_ticks_o <= rtc_ticks_o + 1'b1;
        end
      end else begin
        half_cnt_q <= half_cnt_q + 1'b1;
      end
    end
  end

  // half period counter stays inside its range
  a_half_cnt_range: assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    half_cnt_q <= CNT_W'(`RTC_HALF_CYCLES - 1)
  );

endmodule

`default_nettype wire

// ==== shell_defs.svh ====
`ifndef SHELL_DEFS_SVH
`define SHELL_DEFS_SVH

////////////////////////////////
// register bus widths
////////////////////////////////
`define SHELL_DATA_W 32
`define SHELL_ADDR_W 8

// rtc divider
// 50 MHz soc_clk, 25 cycles high and 25 low give 1 MHz
`define RTC_HALF_CYCLES 25

////////////////////////////////
// fan pwm
////////////////////////////////
`define FAN_LEVEL_W 4
`define FAN_STEP_CYCLES 4
`define FAN_STEPS 16

// register map
`define REG_FAN_OFFS 8'h00
`define REG_RTC_OFFS 8'h04
// read data for unmapped or illegal accesses
`define REG_ERR_VAL 32'hBADCAB1E

`endif

// ==== shell_pkg.sv ====
`default_nettype none

`include "shell_defs.svh"

package shell_pkg;

  ////////////////////////////////
  // bus data types
  ////////////////////////////////

  // one register word
  typedef logic [`SHELL_DATA_W-1:0] data_t;
  // byte address on the register bus
  typedef logic [`SHELL_ADDR_W-1:0] addr_t;

  // pwm duty level, 0 keeps the fan off
  typedef logic [`FAN_LEVEL_W-1:0] fan_level_t;

  // fan register layout
  // bit 4 selects the override, bits 3:0 hold its level
  typedef struct packed {
    logic       ovr_en;
    fan_level_t level;
  } fan_cfg_t;

  ////////////////////////////////
  // enums
  ////////////////////////////////

  // known registers, encoded by their offset
  typedef enum addr_t {
    REG_FAN = `REG_FAN_OFFS,
    REG_RTC = `REG_RTC_OFFS
  } shell_reg_e;

  // response slot of the register target
  typedef enum logic {
    RSP_IDLE    = 1'b0,
    RSP_PENDING = 1'b1
  } rsp_state_e;

endpackage

`default_nettype wire

// ==== spi_host_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// spi host bundle as seen from the soc
// every output comes with its own enable
interface spi_host_if;

  // serial clock
  logic       sck;
  logic       sck_en;
  // chip selects, active low
  logic [1:0] csb;
  logic [1:0] csb_en;
  // data lines toward the pads
  logic [3:0] sd_o;
  logic [3:0] sd_en;
  // data lines back to the host
  logic [3:0] sd_i;

  // soc host controller
  modport host (
    output sck, sck_en, csb, csb_en, sd_o, sd_en,
    input  sd_i
  );

  // pad side adapter
  modport device (
    input  sck, sck_en, csb, csb_en, sd_o, sd_en,
    output sd_i
  );

endinterface

`default_nettype wire

// ==== spi_pad_adapter.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_pad_adapter (
  spi_host_if.device spi,
  // sd card in spi mode
  output logic       sd_cmd_o,
  output logic       sd_sclk_o,
  output logic       sd_cs_o,
  output logic       sd_reset_o,
  input  wire logic  sd_dat0_i,
  // qspi flash
  output logic       qspi_clk_o,
  output logic       qspi_cs_b_o,
  input  wire logic  qspi_dq0_i
);

  logic sd_sel;
  logic qspi_sel;

  // a device is addressed when its select is driven and low
  assign sd_sel   = spi.csb_en[0] && !spi.csb[0];
  assign qspi_sel = spi.csb_en[1] && !spi.csb[1];

  ////////////////////////////////
  // sd card pins
  ////////////////////////////////

  // card power stays on while reset is low
  assign sd_reset_o = 1'b0;
  // sclk, parked high when idle
  assign sd_sclk_o  = spi.sck_en ? spi.sck : 1'b1;
  // chip select 0 on dat3
  assign sd_cs_o    = spi.csb_en[0] ? spi.csb[0] : 1'b1;
  // mosi on cmd
  assign sd_cmd_o   = spi.sd_en[0] ? spi.sd_o[0] : 1'b1;

  ////////////////////////////////
  // qspi flash pins
  ////////////////////////////////

  assign qspi_clk_o  = spi.sck_en ? spi.sck : 1'b1;
  // chip select 1
  assign qspi_cs_b_o = spi.csb_en[1] ? spi.csb[1] : 1'b1;

  // miso back to the host on line 1
  // flash when selected, card otherwise
  assign spi.sd_i[1] = qspi_sel ? qspi_dq0_i : sd_dat0_i;
  // output only lines read back as 0
  assign spi.sd_i[0] = 1'b0;
  assign spi.sd_i[2] = 1'b0;
  assign spi.sd_i[3] = 1'b0;

  // no clock edge while both devices are selected
  a_one_device: assert property (
    @(posedge spi.sck) disable iff (!spi.sck_en)
    !(sd_sel && qspi_sel)
  );

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
shell_pkg.sv
reg_bus_if.sv
spi_host_if.sv
rtc_divider.sv
fan_ctrl.sv
spi_pad_adapter.sv
reg_frontend.sv
board_shell.sv
tb_board_shell.sv

// ==== tb_board_shell.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "shell_defs.svh"

module tb_board_shell;
  import shell_pkg::*;

  // one pwm period in soc_clk cycles
  localparam int PERIOD_CYC = `FAN_STEPS * `FAN_STEP_CYCLES;
  localparam int N_ACCESS   = 60;
  // reset, bus traffic, rtc window, about 20 duty windows, spi cases
  localparam int RUN_CYC    = 10 + N_ACCESS * 16 + 600 + 20 * (2 * PERIOD_CYC + 4) + 100;
  localparam int WATCHDOG_CYC = RUN_CYC + 1000;

  logic       soc_clk = 1'b0;
  logic       rst_n;
  // register bus
  logic       req_valid;
  logic       req_ready;
  logic       req_write;
  addr_t      req_addr;
  data_t      req_wdata;
  logic       rsp_valid;
  logic       rsp_ready;
  data_t      rsp_rdata;
  logic       rsp_error;
  // spi host side
  logic       spi_sck;
  logic       spi_sck_en;
  logic [1:0] spi_csb;
  logic [1:0] spi_csb_en;
  logic [3:0] spi_sd_out;
  logic [3:0] spi_sd_en;
  logic [3:0] spi_sd_in;
  // fan, rtc and pads
  fan_level_t fan_sw;
  logic       fan_pwm;
  logic       rtc_clk;
  logic       sd_cmd;
  logic       sd_sclk;
  logic       sd_cs;
  logic       sd_reset;
  logic       sd_dat0;
  logic       qspi_clk;
  logic       qspi_cs_b;
  logic       qspi_dq0;

  integer   seed = 32'he1bc_7bd0;
  logic     stall_en = 1'b0;
  logic     stall_bit = 1'b1;
  int       errors = 0;
  int       checks = 0;
  int       tests_run = 0;
  int       cyc_cnt = 0;
  int       last_toggle = -1;
  logic     rtc_prev = 1'b0;
  logic     rtc_watch = 1'b0;
  data_t    rtc_seen = '0;
  // what the fan register should hold
  fan_cfg_t fan_shadow = '0;
  // expected responses in order
  data_t    exp_data_q[$];
  logic     exp_err_q[$];
  logic     exp_rtc_q[$];

  // 100 ns period
  always #50 soc_clk = ~soc_clk;

  // random back-pressure with 3 out of 4 cycles ready
  always @(negedge soc_clk) begin
    stall_bit = ($random(seed) & 3) != 0;
  end
  assign rsp_ready = stall_en ? stall_bit : 1'b1;

  board_shell i_board_shell (
    .soc_clk         ( soc_clk    ),
    .rst_n           ( rst_n      ),
    .reg_req_valid_i ( req_valid  ),
    .reg_req_ready_o ( req_ready  ),
    .reg_req_write_i ( req_write  ),
    .reg_req_addr_i  ( req_addr   ),
    .reg_req_wdata_i ( req_wdata  ),
    .reg_rsp_valid_o ( rsp_valid  ),
    .reg_rsp_ready_i ( rsp_ready  ),
    .reg_rsp_rdata_o ( rsp_rdata  ),
    .reg_rsp_error_o ( rsp_error  ),
    .spih_sck_i      ( spi_sck    ),
    .spih_sck_en_i   ( spi_sck_en ),
    .spih_csb_i      ( spi_csb    ),
    .spih_csb_en_i   ( spi_csb_en ),
    .spih_sd_i       ( spi_sd_out ),
    .spih_sd_en_i    ( spi_sd_en  ),
    .spih_sd_o       ( spi_sd_in  ),
    .fan_sw_i        ( fan_sw     ),
    .fan_pwm_o       ( fan_pwm    ),
    .rtc_clk_o       ( rtc_clk    ),
    .sd_cmd_o        ( sd_cmd     ),
    .sd_sclk_o       ( sd_sclk    ),
    .sd_cs_o         ( sd_cs      ),
    .sd_reset_o      ( sd_reset   ),
    .sd_dat0_i       ( sd_dat0    ),
    .qspi_clk_o      ( qspi_clk   ),
    .qspi_cs_b_o     ( qspi_cs_b  ),
    .qspi_dq0_i      ( qspi_dq0   )
  );

  ////////////////////////////////
  // reference model
  ////////////////////////////////

  // expected response for one request
  function automatic void ref_response(input logic write, input addr_t addr,
      input data_t wdata, input fan_cfg_t fan, input data_t ticks,
      output data_t rdata, output logic err);
    rdata = '0;
    err   = 1'b0;
    if (addr == `REG_FAN_OFFS) begin
      // fan read gives the five bits and a write returns zero
      if (!write) begin
        rdata = data_t'(fan);
      end
    end else if (addr == `REG_RTC_OFFS && !write) begin
      rdata = ticks;
    end else begin
      // rtc write or unmapped
      rdata = `REG_ERR_VAL;
      err   = 1'b1;
    end
  endfunction

  // override wins over the switches
  function automatic fan_level_t expected_level(input fan_level_t sw, input fan_cfg_t cfg);
    return cfg.ovr_en ? cfg.level : sw;
  endfunction

  // idle pins park high
  function automatic logic pad_value(input logic en, input logic val);
    return en ? val : 1'b1;
  endfunction

  ////////////////////////////////
  // compare tasks
  ////////////////////////////////

  task automatic check_data(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_level(input string name, input fan_level_t got, input fan_level_t exp);
    checks++;
    if (got !== exp) begin
      $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: passed", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  ////////////////////////////////
  // monitors
  ////////////////////////////////

  // rtc edges and toggle spacing
  always @(posedge soc_clk) begin
    cyc_cnt = cyc_cnt + 1;
    if (rst_n && rtc_clk !== rtc_prev) begin
      if (rtc_watch && last_toggle >= 0) begin
        check_data("rtc_clk_o half period", data_t'(cyc_cnt - last_toggle),
                   data_t'(`RTC_HALF_CYCLES));
      end
      last_toggle = cyc_cnt;
      if (rtc_clk) begin
        rtc_seen = rtc_seen + 1;
      end
    end
    rtc_prev = rtc_clk;
  end

  // completed responses against the queue
  always @(posedge soc_clk) begin : compare_rsp
    data_t exp_data;
    logic  exp_err;
    logic  exp_rtc;
    if (rst_n) begin
      if (req_valid && req_ready && rsp_valid) begin
        $display("a request was accepted while a response was still pending");
        errors++;
      end
      if (rsp_valid && rsp_ready) begin
        if (exp_data_q.size() == 0) begin
          $display("a response completed with no request outstanding");
          errors++;
        end else begin
          exp_data = exp_data_q.pop_front();
          exp_err  = exp_err_q.pop_front();
          exp_rtc  = exp_rtc_q.pop_front();
          // a tick may land between our count and the capture
          if (exp_rtc && (rsp_rdata == exp_data + 1 || rsp_rdata + 1 == exp_data)) begin
            exp_data = rsp_rdata;
          end
          check_data("reg_rsp_rdata_o", rsp_rdata, exp_data);
          check_bit("reg_rsp_error_o", rsp_error, exp_err);
        end
      end
    end
  end

  ////////////////////////////////
  // bus and pad drivers
  ////////////////////////////////

  // one request that returns on the accepting edge
  task automatic bus_access(input logic write, input addr_t addr, input data_t wdata);
    data_t exp_data;
    logic  exp_err;
    int    waited;
    @(negedge soc_clk);
    req_valid = 1'b1;
    req_write = write;
    req_addr  = addr;
    req_wdata = wdata;
    waited    = 0;
    @(posedge soc_clk);
    while (!req_ready && waited < 100) begin
      waited++;
      @(posedge soc_clk);
    end
    if (!req_ready) begin
      $display("request to address 0x%h was never accepted", addr);
      errors++;
    end else begin
      ref_response(write, addr, wdata, fan_shadow, rtc_seen, exp_data, exp_err);
      exp_data_q.push_back(exp_data);
      exp_err_q.push_back(exp_err);
      exp_rtc_q.push_back(!write && addr == `REG_RTC_OFFS);
      if (write && addr == `REG_FAN_OFFS) begin
        fan_shadow = fan_cfg_t'(wdata[$bits(fan_cfg_t)-1:0]);
      end
    end
  endtask

  // stop requesting and wait for every response
  task automatic drain_bus();
    int waited;
    @(negedge soc_clk);
    req_valid = 1'b0;
    waited    = 0;
    while ((exp_data_q.size() != 0 || rsp_valid) && waited < 200) begin
      waited++;
      @(posedge soc_clk);
    end
    if (exp_data_q.size() != 0) begin
      $display("%0d responses never arrived", exp_data_q.size());
      errors++;
    end
  endtask

  // level is latched within one period and any later full window holds it
  task automatic check_duty(input fan_level_t exp_level);
    data_t high;
    repeat (PERIOD_CYC + 2) @(posedge soc_clk);
    high = '0;
    repeat (PERIOD_CYC) begin
      @(posedge soc_clk);
      if (fan_pwm) begin
        high = high + 1;
      end
    end
    check_data("fan_pwm_o high cycles", high, data_t'(exp_level) * `FAN_STEP_CYCLES);
    check_level("fan_pwm_o level", fan_level_t'(high / `FAN_STEP_CYCLES), exp_level);
  endtask

  // sel 0 picks the card and sel 1 the flash while other values disable every pin
  task automatic spi_case(input int sel);
    logic [31:0] bits;
    bits = $random(seed);
    @(negedge soc_clk);
    spi_sck    = bits[0];
    spi_sck_en = (sel == 0 || sel == 1);
    spi_sd_out = bits[7:4];
    spi_sd_en  = (sel == 0 || sel == 1) ? (bits[11:8] | 4'b0001) : 4'b0000;
    sd_dat0    = bits[12];
    qspi_dq0   = bits[13];
    case (sel)
      0: begin
        spi_csb_en = 2'b01;
        spi_csb    = 2'b10;
      end
      1: begin
        spi_csb_en = 2'b10;
        spi_csb    = 2'b01;
      end
      default: begin
        spi_csb_en = 2'b00;
        spi_csb    = bits[15:14];
      end
    endcase
    @(posedge soc_clk);
    check_bit("sd_sclk_o", sd_sclk, pad_value(spi_sck_en, spi_sck));
    check_bit("qspi_clk_o", qspi_clk, pad_value(spi_sck_en, spi_sck));
    check_bit("sd_cs_o", sd_cs, pad_value(spi_csb_en[0], spi_csb[0]));
    check_bit("qspi_cs_b_o", qspi_cs_b, pad_value(spi_csb_en[1], spi_csb[1]));
    check_bit("sd_cmd_o", sd_cmd, pad_value(spi_sd_en[0], spi_sd_out[0]));
    check_bit("sd_reset_o", sd_reset, 1'b0);
    // unused data lines back to the host read 0
    check_bit("spih_sd_o[0]", spi_sd_in[0], 1'b0);
    check_bit("spih_sd_o[2]", spi_sd_in[2], 1'b0);
    check_bit("spih_sd_o[3]", spi_sd_in[3], 1'b0);
    // miso from the selected device
    if (sel == 0) begin
      check_bit("spih_sd_o[1]", spi_sd_in[1], sd_dat0);
    end else if (sel == 1) begin
      check_bit("spih_sd_o[1]", spi_sd_in[1], qspi_dq0);
    end
  endtask

  ////////////////////////////////
  // test sequence
  ////////////////////////////////

  initial begin : stimulus
    int          err_mark;
    data_t       ticks_start;
    logic [31:0] bits;
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req_write  = 1'b0;
    req_addr   = '0;
    req_wdata  = '0;
    spi_sck    = 1'b0;
    spi_sck_en = 1'b0;
    spi_csb    = 2'b11;
    spi_csb_en = 2'b00;
    spi_sd_out = '0;
    spi_sd_en  = '0;
    fan_sw     = '0;
    sd_dat0    = 1'b0;
    qspi_dq0   = 1'b0;
    repeat (4) @(negedge soc_clk);
    rst_n = 1'b1;

    // random register traffic under back-pressure
    err_mark = errors;
    stall_en = 1'b1;
    repeat (N_ACCESS) begin
      bits = $random(seed);
      case (bits[1:0])
        2'd0:    bus_access(1'b1, `REG_FAN_OFFS, data_t'($random(seed)));
        2'd1:    bus_access(1'b0, `REG_FAN_OFFS, '0);
        2'd2:    bus_access(1'b1, bits[15:8], data_t'($random(seed)));
        default: bus_access(1'b0, bits[15:8], '0);
      endcase
    end
    drain_bus();
    stall_en = 1'b0;
    end_test("register access", err_mark);

    // rtc gives one rising edge per 2 x 25 cycles
    err_mark  = errors;
    rtc_watch = 1'b1;
    @(negedge soc_clk);
    ticks_start = rtc_seen;
    repeat (500) @(negedge soc_clk);
    check_data("rtc ticks over 500 cycles", rtc_seen - ticks_start,
               data_t'(500 / (2 * `RTC_HALF_CYCLES)));
    bus_access(1'b0, `REG_RTC_OFFS, '0);
    bus_access(1'b1, `REG_RTC_OFFS, data_t'($random(seed)));
    drain_bus();
    rtc_watch = 1'b0;
    end_test("rtc divider", err_mark);

    // every switch level with the override cleared
    err_mark = errors;
    bus_access(1'b1, `REG_FAN_OFFS, '0);
    drain_bus();
    for (int lvl = 0; lvl < `FAN_STEPS; lvl++) begin
      @(negedge soc_clk);
      fan_sw = fan_level_t'(lvl);
      check_duty(expected_level(fan_sw, fan_shadow));
    end
    end_test("fan pwm from switches", err_mark);

    // override on with the switches ignored and then back off
    err_mark = errors;
    @(negedge soc_clk);
    fan_sw = 4'd3;
    bus_access(1'b1, `REG_FAN_OFFS, 32'h0000_001b);
    bus_access(1'b0, `REG_FAN_OFFS, '0);
    drain_bus();
    check_duty(expected_level(fan_sw, fan_shadow));
    @(negedge soc_clk);
    fan_sw = 4'd7;
    check_duty(expected_level(fan_sw, fan_shadow));
    bus_access(1'b1, `REG_FAN_OFFS, 32'h0000_0005);
    drain_bus();
    check_duty(expected_level(fan_sw, fan_shadow));
    end_test("fan override", err_mark);

    // pads for card, flash and idle
    err_mark = errors;
    repeat (8) begin
      spi_case(0);
      spi_case(1);
      spi_case(2);
    end
    end_test("spi pads", err_mark);

    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // hard stop if the sequence stalls
  initial begin : watchdog
    repeat (WATCHDOG_CYC) @(posedge soc_clk);
    $display("watchdog expired after %0d cycles, the tests did not complete", WATCHDOG_CYC);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire
